/* include/mcu_settings.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PROG_DEPTH must be a power of two, since the pc wraps at its width.
// GPIO_WIDTH may not exceed the 8-bit data bus.
// LED_COUNT_LEN is a board default; board_wrapper takes it as a parameter.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

`define PROG_DEPTH 64
`define PC_WIDTH $clog2(`PROG_DEPTH)
`define DRAM_DEPTH 16
`define GPIO_WIDTH 8
`define LED_COUNT_LEN 27

// peripheral byte addresses
`define ADDR_GPIO_OUT 8'hF0
`define ADDR_GPIO_IN 8'hF1
`define ADDR_EXIT 8'hF2

`endif

/* design/mcu_isa_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction word is {opcode[3:0], operand[7:0]}, 12 bits.
// Opcode codes not listed here execute as HALT.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mcu_isa_pkg;

  typedef enum logic [3:0] {
    OP_HALT = 4'h0,
    OP_LDI  = 4'h1,
    OP_ADDI = 4'h2,
    OP_XORI = 4'h3,
    OP_LD   = 4'h4,
    OP_ST   = 4'h5,
    OP_JNZ  = 4'h6
  } opcode_e;

  typedef struct packed {
    opcode_e    op;
    logic [7:0] operand;
  } instr_t;

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    FETCH  = 3'd1,
    EXEC   = 3'd2,
    LOAD   = 3'd3,
    HALTED = 3'd4
  } core_state_e;

endpackage

/* design/mcu_bus_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Both structs carry single-cycle strobes with no back-pressure.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mcu_settings.svh"

package mcu_bus_pkg;

  // data bus request from the core
  typedef struct packed {
    logic       stb;
    logic       we;
    logic [7:0] addr;
    logic [7:0] wdata;
  } bus_req_t;

  // host program write, one word per strobe
  typedef struct packed {
    logic                  stb;
    logic [`PC_WIDTH-1:0]  addr;
    mcu_isa_pkg::instr_t   instr;
  } prog_wr_t;

endpackage

/* design/tiny_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accumulator core. Each instruction takes FETCH and EXEC, LD adds LOAD.
// boot_i is honoured only in IDLE or HALTED; instr_i lags fetch by 1.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mcu_settings.svh"

module tiny_core (
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  logic                  boot_i,
  output logic [`PC_WIDTH-1:0]  fetch_addr_o,
  input  mcu_isa_pkg::instr_t   instr_i,
  output mcu_bus_pkg::bus_req_t bus_req_o,
  input  logic [7:0]            bus_rdata_i,
  output logic                  halted_o
);
  import mcu_isa_pkg::*;

  core_state_e          state_q;
  core_state_e          state_d;
  logic [`PC_WIDTH-1:0] pc_q;
  logic [`PC_WIDTH-1:0] pc_d;
  logic [7:0]           acc_q;
  logic [7:0]           acc_d;

  assign fetch_addr_o = pc_q;
  assign halted_o     = (state_q == HALTED);

  always_comb begin
    state_d   = state_q;
    pc_d      = pc_q;
    acc_d     = acc_q;
    bus_req_o = '0;

    case (state_q)
      IDLE, HALTED: begin
        if (boot_i) begin
          state_d = FETCH;
          pc_d    = '0;
          acc_d   = '0;
        end
      end

      // prog_mem answers in the next cycle
      FETCH: state_d = EXEC;

      EXEC: begin
        state_d = FETCH;
        pc_d    = pc_q + 1'b1;
        case (instr_i.op)
          OP_LDI:  acc_d = instr_i.operand;
          OP_ADDI: acc_d = acc_q + instr_i.operand;
          OP_XORI: acc_d = acc_q ^ instr_i.operand;
          OP_ST: begin
            bus_req_o.stb   = 1'b1;
            bus_req_o.we    = 1'b1;
            bus_req_o.addr  = instr_i.operand;
            bus_req_o.wdata = acc_q;
          end
          OP_LD: begin
            bus_req_o.stb  = 1'b1;
            bus_req_o.addr = instr_i.operand;
            state_d        = LOAD;
          end
          OP_JNZ: begin
            if (acc_q != 8'd0) begin
              pc_d = instr_i.operand[`PC_WIDTH-1:0];
            end
          end
          OP_HALT: begin
            state_d = HALTED;
            pc_d    = pc_q;
          end
          // undefined codes stop the core as well
          default: begin
            state_d = HALTED;
            pc_d    = pc_q;
          end
        endcase
      end

      // read data registered by the system
      LOAD: begin
        acc_d   = bus_rdata_i;
        state_d = FETCH;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      pc_q    <= '0;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
    end
  end

endmodule

/* design/prog_mem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Contents undefined until loaded; host loads only while core is idle
// or halted. Read is synchronous, old data on same-address write.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mcu_settings.svh"

module prog_mem (
  input  logic                  clk_gen,
  input  mcu_bus_pkg::prog_wr_t prog_wr_i,
  input  logic [`PC_WIDTH-1:0]  fetch_addr_i,
  output mcu_isa_pkg::instr_t   instr_o
);
  import mcu_isa_pkg::*;

  instr_t mem_q [`PROG_DEPTH];

  // host write port
  always_ff @(posedge clk_gen) begin
    if (prog_wr_i.stb) begin
      mem_q[prog_wr_i.addr] <= prog_wr_i.instr;
    end
  end

  // fetch port
  always_ff @(posedge clk_gen) begin
    instr_o <= mem_q[fetch_addr_i];
  end

endmodule

/* design/periph_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decodes only addr[1:0]; the system must qualify accesses with sel_i.
// GPIO_IN reads return gpio_i as sampled one cycle earlier.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mcu_settings.svh"

module periph_regs (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  logic                   boot_i,
  input  logic                   sel_i,
  input  mcu_bus_pkg::bus_req_t  bus_req_i,
  output logic [7:0]             rdata_o,
  input  logic [`GPIO_WIDTH-1:0] gpio_i,
  output logic [`GPIO_WIDTH-1:0] gpio_o,
  output logic [7:0]             exit_value_o,
  output logic                   exit_valid_o
);

  localparam logic [7:0] GPIO_OUT_ADDR = `ADDR_GPIO_OUT;
  localparam logic [7:0] GPIO_IN_ADDR  = `ADDR_GPIO_IN;
  localparam logic [7:0] EXIT_ADDR     = `ADDR_EXIT;

  logic [`GPIO_WIDTH-1:0] gpio_out_q;
  logic [`GPIO_WIDTH-1:0] gpio_in_q;
  logic                   wr_en;

  assign wr_en  = sel_i && bus_req_i.stb && bus_req_i.we;
  assign gpio_o = gpio_out_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      gpio_out_q   <= '0;
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else begin
      if (boot_i) begin
        exit_value_o <= '0;
        exit_valid_o <= 1'b0;
      end else if (wr_en && bus_req_i.addr[1:0] == EXIT_ADDR[1:0]) begin
        exit_value_o <= bus_req_i.wdata;
        exit_valid_o <= 1'b1;
      end
      if (wr_en && bus_req_i.addr[1:0] == GPIO_OUT_ADDR[1:0]) begin
        gpio_out_q <= bus_req_i.wdata[`GPIO_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk_gen) begin
    gpio_in_q <= gpio_i;
  end

  always_comb begin
    rdata_o = '0;
    case (bus_req_i.addr[1:0])
      GPIO_OUT_ADDR[1:0]: rdata_o[`GPIO_WIDTH-1:0] = gpio_out_q;
      GPIO_IN_ADDR[1:0]:  rdata_o[`GPIO_WIDTH-1:0] = gpio_in_q;
      EXIT_ADDR[1:0]:     rdata_o = exit_value_o;
      default:            rdata_o = '0;
    endcase
  end

endmodule

/* design/mcu_system.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM at 0x00 up, peripherals at 0xF0..0xF2, rest reads as zero.
// Read data reaches the core one cycle after the strobe.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mcu_settings.svh"

module mcu_system (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  mcu_bus_pkg::prog_wr_t  prog_wr_i,
  input  logic                   boot_i,
  input  logic [`GPIO_WIDTH-1:0] gpio_i,
  output logic [`GPIO_WIDTH-1:0] gpio_o,
  output logic [7:0]             exit_value_o,
  output logic                   exit_valid_o,
  output logic                   halted_o
);
  import mcu_isa_pkg::*;
  import mcu_bus_pkg::*;

  localparam int unsigned DRAM_AW = $clog2(`DRAM_DEPTH);

  logic [`PC_WIDTH-1:0] fetch_addr;
  instr_t               instr;
  bus_req_t             bus_req;
  logic [7:0]           bus_rdata_q;
  logic [7:0]           per_rdata;
  logic                 ram_sel;
  logic                 per_sel;
  logic [7:0]           dram [`DRAM_DEPTH];

  tiny_core u_core (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .boot_i       (boot_i),
    .fetch_addr_o (fetch_addr),
    .instr_i      (instr),
    .bus_req_o    (bus_req),
    .bus_rdata_i  (bus_rdata_q),
    .halted_o     (halted_o)
  );

  prog_mem u_prog_mem (
    .clk_gen      (clk_gen),
    .prog_wr_i    (prog_wr_i),
    .fetch_addr_i (fetch_addr),
    .instr_o      (instr)
  );

  // address decoder
  assign ram_sel = (bus_req.addr < 8'(`DRAM_DEPTH));
  assign per_sel = (bus_req.addr == `ADDR_GPIO_OUT) || (bus_req.addr == `ADDR_GPIO_IN) ||
                   (bus_req.addr == `ADDR_EXIT);

  always_ff @(posedge clk_gen) begin
    if (bus_req.stb && bus_req.we && ram_sel) begin
      dram[bus_req.addr[DRAM_AW-1:0]] <= bus_req.wdata;
    end
  end

  // unmapped reads return zero
  always_ff @(posedge clk_gen) begin
    if (bus_req.stb && !bus_req.we) begin
      if (ram_sel) begin
        bus_rdata_q <= dram[bus_req.addr[DRAM_AW-1:0]];
      end else if (per_sel) begin
        bus_rdata_q <= per_rdata;
      end else begin
        bus_rdata_q <= '0;
      end
    end
  end

  periph_regs u_periph (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .boot_i       (boot_i),
    .sel_i        (per_sel),
    .bus_req_i    (bus_req),
    .rdata_o      (per_rdata),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

/* design/board_wrapper.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock and active-low reset enter directly, no clock wizard.
// clk_led_o toggles every 2**(LED_COUNT_LEN-1) cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mcu_settings.svh"

module board_wrapper #(
  parameter int unsigned LED_COUNT_LEN = `LED_COUNT_LEN
) (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  mcu_bus_pkg::prog_wr_t  prog_wr_i,
  input  logic                   boot_i,
  input  logic [`GPIO_WIDTH-1:0] gpio_i,
  output logic [`GPIO_WIDTH-1:0] gpio_o,
  output logic [7:0]             exit_value_o,
  output logic                   exit_valid_o,
  output logic                   halted_o,
  output logic                   rst_led_o,
  output logic                   clk_led_o
);

  logic [LED_COUNT_LEN-1:0] clk_count_q;

  assign rst_led_o = rst_n;
  assign clk_led_o = clk_count_q[LED_COUNT_LEN-1];

  // heartbeat
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  mcu_system u_system (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .prog_wr_i    (prog_wr_i),
    .boot_i       (boot_i),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o),
    .halted_o     (halted_o)
  );

endmodule

/* verification/tiny_core_asserts.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound into tiny_core. fail_count is read by the testbench at the end.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tiny_core_asserts (
  input logic                     clk_gen,
  input logic                     rst_n,
  input mcu_isa_pkg::core_state_e state_i,
  input mcu_bus_pkg::bus_req_t    bus_req_i,
  input logic                     halted_i
);
  import mcu_isa_pkg::*;

  int unsigned fail_count = 0;

  strobe_single: assert property (@(posedge clk_gen) disable iff (!rst_n)
    bus_req_i.stb |=> !bus_req_i.stb)
    else begin
      fail_count++;
      $error("bus strobe held for two cycles");
    end

  // the core is parked in these states
  no_strobe_parked: assert property (@(posedge clk_gen) disable iff (!rst_n)
    !(bus_req_i.stb && (state_i == IDLE || state_i == HALTED)))
    else begin
      fail_count++;
      $error("bus strobe while core idle or halted");
    end

  // halted_o only rises right after a HALT in EXEC
  halted_from_exec: assert property (@(posedge clk_gen) disable iff (!rst_n)
    $rose(halted_i) |-> ($past(state_i) == EXEC))
    else begin
      fail_count++;
      $error("halted_o rose without a HALT executing in the cycle before");
    end

  load_after_read: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (state_i == EXEC && bus_req_i.stb && !bus_req_i.we) |=> (state_i == LOAD))
    else begin
      fail_count++;
      $error("read strobe in EXEC not followed by LOAD");
    end

endmodule

/* verification/board_wrapper_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Run from the project root; reads verification/golden_programs.txt.
// LED_COUNT_LEN defaults to 4 so the heartbeat shows up within cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mcu_settings.svh"

module board_wrapper_tb #(
  parameter int unsigned LED_COUNT_LEN = 4
);
  import mcu_bus_pkg::*;

  logic                   clk_gen;
  logic                   rst_n;
  prog_wr_t               prog_wr;
  logic                   boot;
  logic [`GPIO_WIDTH-1:0] gpio_in;
  logic [`GPIO_WIDTH-1:0] gpio_out;
  logic [7:0]             exit_value;
  logic                   exit_valid;
  logic                   halted;
  logic                   rst_led;
  logic                   clk_led;
  byte unsigned           rec_kind [$];
  logic [11:0]            rec_a [$];
  logic [11:0]            rec_b [$];
  int unsigned            run_count;
  int unsigned            errors;
  int unsigned            checks;
  logic                   armed;

  initial clk_gen = 1'b0;
  always #4 clk_gen = ~clk_gen;

  board_wrapper #(.LED_COUNT_LEN(LED_COUNT_LEN)) dut (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .prog_wr_i    (prog_wr),
    .boot_i       (boot),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .exit_value_o (exit_value),
    .exit_valid_o (exit_valid),
    .halted_o     (halted),
    .rst_led_o    (rst_led),
    .clk_led_o    (clk_led)
  );

  bind tiny_core tiny_core_asserts u_asserts (
    .clk_gen   (clk_gen),
    .rst_n     (rst_n),
    .state_i   (state_q),
    .bus_req_i (bus_req_o),
    .halted_i  (halted_o)
  );

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  // record lines are P, G, R or E; anything else is skipped
  task automatic load_golden();
    int           fd;
    int           n;
    string        line;
    byte unsigned kind;
    logic [11:0]  a;
    logic [11:0]  b;
    fd = $fopen("verification/golden_programs.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open verification/golden_programs.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        kind = 8'd0;
        a    = '0;
        b    = '0;
        n    = $fgets(line, fd);
        n    = $sscanf(line, "%c %h %h", kind, a, b);
        if (kind == "P" || kind == "G" || kind == "R" || kind == "E") begin
          rec_kind.push_back(kind);
          rec_a.push_back(a);
          rec_b.push_back(b);
          if (kind == "R") run_count++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_word(input logic [11:0] addr, input logic [11:0] word);
    prog_wr.stb   = 1'b1;
    prog_wr.addr  = addr[`PC_WIDTH-1:0];
    prog_wr.instr = word;
    @(posedge clk_gen);
    #1;
    prog_wr.stb   = 1'b0;
  endtask

  task automatic run_program();
    int cycles;
    boot = 1'b1;
    @(posedge clk_gen);
    #1;
    boot = 1'b0;
    // boot clears the exit register before anything runs
    check_value("exit_valid_o", 8'd0, 8'(exit_valid));
    check_value("halted_o", 8'd0, 8'(halted));
    cycles = 0;
    while (!halted && cycles < 64 * `PROG_DEPTH) begin
      @(posedge clk_gen);
      #1;
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("core did not halt within %0d cycles at t=%0t", cycles, $time);
    end
  endtask

  task automatic check_idle_outputs(input logic exp_rst_led);
    check_value("gpio_o", 8'd0, 8'(gpio_out));
    check_value("exit_value_o", 8'd0, exit_value);
    check_value("exit_valid_o", 8'd0, 8'(exit_valid));
    check_value("halted_o", 8'd0, 8'(halted));
    check_value("rst_led_o", 8'(exp_rst_led), 8'(rst_led));
  endtask

  task automatic check_heartbeat();
    int half;
    half = 1 << (LED_COUNT_LEN - 1);
    for (int i = 1; i < half; i++) begin
      @(posedge clk_gen);
      #1;
      check_value("clk_led_o", 8'd0, 8'(clk_led));
    end
    @(posedge clk_gen);
    #1;
    check_value("clk_led_o", 8'd1, 8'(clk_led));
  endtask

  initial begin
    rst_n     = 1'b0;
    boot      = 1'b0;
    gpio_in   = '0;
    prog_wr   = '0;
    errors    = 0;
    checks    = 0;
    run_count = 0;
    armed     = 1'b0;
    load_golden();
    if (rec_kind.size() == 0) begin
      errors++;
      $display("no records found in the golden file");
    end
    armed = 1'b1;
    repeat (10) @(posedge clk_gen);
    #1;
    check_idle_outputs(1'b0);
    rst_n = 1'b1;
    check_heartbeat();
    check_idle_outputs(1'b1);
    foreach (rec_kind[i]) begin
      case (rec_kind[i])
        "P": write_word(rec_a[i], rec_b[i]);
        "G": gpio_in = rec_a[i][`GPIO_WIDTH-1:0];
        "R": run_program();
        "E": begin
          check_value("gpio_o", rec_a[i][7:0], 8'(gpio_out));
          check_value("exit_value_o", rec_b[i][7:0], exit_value);
          check_value("exit_valid_o", 8'd1, 8'(exit_valid));
        end
        default: ;
      endcase
    end
    $display("checks=%0d errors=%0d assertion_failures=%0d", checks, errors,
             dut.u_system.u_core.u_asserts.fail_count);
    if (errors == 0 && dut.u_system.u_core.u_asserts.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // limit grows with the number of programs in the golden file
  initial begin
    int unsigned limit;
    wait (armed);
    limit = run_count * 64 * `PROG_DEPTH + rec_kind.size() + 64;
    repeat (limit) @(posedge clk_gen);
    $display("watchdog expired after %0d cycles before the tests finished", limit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* verification/golden_programs.txt */
# P <pc hex> <word hex> | G <gpio_i hex> | R (boot, wait halt) | E <gpio_o hex> <exit hex>
# word = {opcode, operand}: 0 HALT 1 LDI 2 ADDI 3 XORI 4 LD 5 ST 6 JNZ
P 00 1C8
P 01 264
P 02 5F0
P 03 35A
P 04 2FF
P 05 5F2
P 06 000
R
E 2C 75
P 00 100
P 01 501
P 02 106
P 03 500
P 04 401
P 05 233
P 06 501
P 07 400
P 08 2FF
P 09 500
P 0A 604
P 0B 401
P 0C 5F2
P 0D 000
R
E 2C 32
G A5
P 00 4F1
P 01 33C
P 02 5F0
P 03 5F2
P 04 000
R
E 99 99
P 00 17E
P 01 580
P 02 5F4
P 03 481
P 04 2C3
P 05 5F2
P 06 000
R
E 99 C3

/* filelist.f */
+incdir+include
design/mcu_isa_pkg.sv
design/mcu_bus_pkg.sv
design/tiny_core.sv
design/prog_mem.sv
design/periph_regs.sv
design/mcu_system.sv
design/board_wrapper.sv
verification/tiny_core_asserts.sv
verification/board_wrapper_tb.sv

/* Makefile */
VERILATOR     ?= verilator
TOP           ?= board_wrapper_tb
FILELIST      ?= filelist.f
OBJ_DIR       ?= obj_dir
LED_COUNT_LEN ?= 4
ERROR_LIMIT   ?= 1000
VFLAGS        ?= --timing --assert -GLED_COUNT_LEN=$(LED_COUNT_LEN)
PASS_MSG      := Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out=$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
